/* logic/rv_pkg.sv */
package rv_pkg;

  // ============================================================
  // widths and opcodes
  // ============================================================

  localparam int XLEN = 32;

  localparam logic [6:0] OP     = 7'b0110011;
  localparam logic [6:0] OP_IMM = 7'b0010011;
  localparam logic [6:0] LUI    = 7'b0110111;
  localparam logic [6:0] AUIPC  = 7'b0010111;
  localparam logic [6:0] JAL    = 7'b1101111;
  localparam logic [6:0] JALR   = 7'b1100111;
  localparam logic [6:0] BRANCH = 7'b1100011;

  // funct3 values for ALU ops
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct3 values for the two kept branches
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_t;

  // ============================================================
  // decode controls and stage payloads
  // ============================================================

  typedef struct packed {
    logic    reg_write;
    logic    alu_src_imm;
    logic    pc_as_op1;
    logic    is_lui;
    logic    is_branch;
    logic    branch_ne;
    logic    is_jal;
    logic    is_jalr;
    alu_op_t alu_op;
  } ctrl_t;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [31:0]     instr;
  } if_id_t;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] imm;
    ctrl_t           ctrl;
  } id_ex_t;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [4:0]      rd;
    logic [XLEN-1:0] result;
    logic            reg_write;
  } ex_wb_t;

endpackage

/* logic/wb_if.sv */
`timescale 1ns/1ps

// writeback bundle, rd is already zero when nothing is written
interface wb_if;
  logic        valid;
  logic [4:0]  rd;
  logic [31:0] data;
  logic [31:0] pc;

  modport source (
    output valid, rd, data, pc
  );

  modport sink (
    input valid, rd, data, pc
  );

endinterface

/* logic/pipe_stage_reg.sv */
`timescale 1ns/1ps

module pipe_stage_reg
  import rv_pkg::*;
#(
  parameter type payload_t = logic [XLEN-1:0]
) (
  input  logic     clk,
  input  logic     rst_n_i,
  input  logic     flush_i,
  input  logic     valid_i,
  input  payload_t data_i,
  output logic     valid_o,
  output payload_t data_o
);

  // flush has priority over capture
  always_ff @(posedge clk) begin
    if (!rst_n_i || flush_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // payload is qualified by valid_o only
  always_ff @(posedge clk) begin
    data_o <= data_i;
  end

  assert property (@(posedge clk) disable iff (!rst_n_i) !$isunknown(valid_o))
    else $error("stage valid is unknown after reset");

endmodule

/* logic/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit
  import rv_pkg::*;
#(
  parameter logic [XLEN-1:0] RESET_PC = '0
) (
  input  logic            clk,
  input  logic            rst_n_i,
  input  logic            redirect_i,
  input  logic [XLEN-1:0] redirect_pc_i,
  output logic [XLEN-1:0] pc_o
);

  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] pc_next;

  // redirect from execute beats sequential fetch
  always_comb begin
    if (redirect_i) begin
      pc_next = redirect_pc_i;
    end else begin
      pc_next = pc_q + XLEN'(4);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      pc_q <= RESET_PC;
    end else begin
      pc_q <= pc_next;
    end
  end

  assign pc_o = pc_q;

  // reset value and every redirect target must keep fetch aligned
  assert property (@(posedge clk) disable iff (!rst_n_i) pc_q[1:0] == 2'b00)
    else $error("fetch pc not word aligned: %h", pc_q);

endmodule

/* logic/reg_file.sv */
`timescale 1ns/1ps

module reg_file
  import rv_pkg::*;
(
  input  logic            clk,
  input  logic [4:0]      rs1_i,
  input  logic [4:0]      rs2_i,
  output logic [XLEN-1:0] rs1_data_o,
  output logic [XLEN-1:0] rs2_data_o,
  wb_if.sink              wb
);

  logic [XLEN-1:0] regs [32];
  logic            wr_en;

  // rd is zeroed upstream for non-writing instructions
  assign wr_en = wb.valid && (wb.rd != 5'd0);

  // x0 storage cleared every cycle and never taken by the write port
  always_ff @(posedge clk) begin
    regs[0] <= '0;
    if (wr_en) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // write-first, so the instruction in writeback is seen by decode
  assign rs1_data_o = (wr_en && wb.rd == rs1_i) ? wb.data : regs[rs1_i];
  assign rs2_data_o = (wr_en && wb.rd == rs2_i) ? wb.data : regs[rs2_i];

  assert property (@(posedge clk) (rs1_i == 5'd0) |-> (rs1_data_o == '0))
    else $error("x0 read on port 1 returned %h", rs1_data_o);

  assert property (@(posedge clk) (rs2_i == 5'd0) |-> (rs2_data_o == '0))
    else $error("x0 read on port 2 returned %h", rs2_data_o);

endmodule

/* logic/decode_unit.sv */
`timescale 1ns/1ps

module decode_unit
  import rv_pkg::*;
(
  input  if_id_t in_i,
  wb_if.sink     wb,
  input  logic   clk,
  output id_ex_t out_o
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [4:0]      rs1;
  logic [4:0]      rs2;
  logic [4:0]      rd;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  ctrl_t           ctrl;

  // sub only exists in the register form, sra in both
  function automatic alu_op_t alu_decode(input logic [2:0] f3, input logic f7b5,
                                         input logic is_reg);
    case (f3)
      F3_ADD_SUB: return (is_reg && f7b5) ? ALU_SUB : ALU_ADD;
      F3_SLL:     return ALU_SLL;
      F3_SLT:     return ALU_SLT;
      F3_SLTU:    return ALU_SLTU;
      F3_XOR:     return ALU_XOR;
      F3_SRL_SRA: return f7b5 ? ALU_SRA : ALU_SRL;
      F3_OR:      return ALU_OR;
      default:    return ALU_AND;
    endcase
  endfunction

  assign opcode = in_i.instr[6:0];
  assign rd     = in_i.instr[11:7];
  assign funct3 = in_i.instr[14:12];
  assign rs1    = in_i.instr[19:15];
  assign rs2    = in_i.instr[24:20];
  assign funct7 = in_i.instr[31:25];

  // ============================================================
  // immediates
  // ============================================================

  assign imm_i = {{20{in_i.instr[31]}}, in_i.instr[31:20]};
  assign imm_u = {in_i.instr[31:12], 12'b0};
  assign imm_j = {{12{in_i.instr[31]}}, in_i.instr[19:12], in_i.instr[20],
                  in_i.instr[30:21], 1'b0};
  assign imm_b = {{20{in_i.instr[31]}}, in_i.instr[7], in_i.instr[30:25],
                  in_i.instr[11:8], 1'b0};

  // ============================================================
  // control decode
  // ============================================================

  always_comb begin
    ctrl        = '0;
    ctrl.alu_op = ALU_ADD;
    imm         = imm_i;
    case (opcode)
      OP: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = alu_decode(funct3, funct7[5], 1'b1);
      end
      OP_IMM: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.alu_op      = alu_decode(funct3, funct7[5], 1'b0);
      end
      LUI: begin
        ctrl.reg_write = 1'b1;
        ctrl.is_lui    = 1'b1;
        imm            = imm_u;
      end
      AUIPC: begin
        ctrl.reg_write   = 1'b1;
        ctrl.pc_as_op1   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        imm              = imm_u;
      end
      JAL: begin
        ctrl.reg_write = 1'b1;
        ctrl.pc_as_op1 = 1'b1;
        ctrl.is_jal    = 1'b1;
        imm            = imm_j;
      end
      JALR: begin
        ctrl.reg_write = 1'b1;
        ctrl.pc_as_op1 = 1'b1;
        ctrl.is_jalr   = 1'b1;
      end
      BRANCH: begin
        // only beq and bne, anything else stays a no-op
        ctrl.is_branch = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
        ctrl.branch_ne = (funct3 == F3_BNE);
        imm            = imm_b;
      end
      default: begin
        ctrl.reg_write = 1'b0;
      end
    endcase
  end

  reg_file u_reg_file (
    .clk        (clk),
    .rs1_i      (rs1),
    .rs2_i      (rs2),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .wb         (wb)
  );

  assign out_o = '{pc: in_i.pc, rs1: rs1, rs2: rs2, rd: rd, rs1_data: rs1_data,
                   rs2_data: rs2_data, imm: imm, ctrl: ctrl};

endmodule

/* logic/execute_unit.sv */
`timescale 1ns/1ps

module execute_unit
  import rv_pkg::*;
(
  input  logic            clk,
  input  id_ex_t          in_i,
  input  logic            valid_i,
  wb_if.sink              wb,
  output ex_wb_t          out_o,
  output logic            redirect_o,
  output logic [XLEN-1:0] redirect_pc_o
);

  logic [XLEN-1:0] rs1_fwd;
  logic [XLEN-1:0] rs2_fwd;
  logic [XLEN-1:0] op1;
  logic [XLEN-1:0] op2;
  logic [4:0]      shamt;
  logic [XLEN-1:0] alu_res;
  logic [XLEN-1:0] link_pc;
  logic [XLEN-1:0] result;
  logic            branch_taken;

  // ============================================================
  // forwarding from writeback
  // ============================================================

  // the one-ahead instruction sits in writeback now
  assign rs1_fwd = (wb.valid && wb.rd != 5'd0 && wb.rd == in_i.rs1) ? wb.data : in_i.rs1_data;
  assign rs2_fwd = (wb.valid && wb.rd != 5'd0 && wb.rd == in_i.rs2) ? wb.data : in_i.rs2_data;

  assign op1   = in_i.ctrl.pc_as_op1 ? in_i.pc : rs1_fwd;
  assign op2   = in_i.ctrl.alu_src_imm ? in_i.imm : rs2_fwd;
  assign shamt = op2[4:0];

  // ============================================================
  // ALU
  // ============================================================

  always_comb begin
    case (in_i.ctrl.alu_op)
      ALU_ADD:  alu_res = op1 + op2;
      ALU_SUB:  alu_res = op1 - op2;
      ALU_SLL:  alu_res = op1 << shamt;
      ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
      ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, op1 < op2};
      ALU_XOR:  alu_res = op1 ^ op2;
      ALU_SRL:  alu_res = op1 >> shamt;
      ALU_SRA:  alu_res = $unsigned($signed(op1) >>> shamt);
      ALU_OR:   alu_res = op1 | op2;
      ALU_AND:  alu_res = op1 & op2;
      default:  alu_res = '0;
    endcase
  end

  assign link_pc = in_i.pc + XLEN'(4);

  // branches carry zero data so the trace stays clean
  always_comb begin
    if (!in_i.ctrl.reg_write) begin
      result = '0;
    end else if (in_i.ctrl.is_lui) begin
      result = in_i.imm;
    end else if (in_i.ctrl.is_jal || in_i.ctrl.is_jalr) begin
      result = link_pc;
    end else begin
      result = alu_res;
    end
  end

  // ============================================================
  // branch and jump resolution
  // ============================================================

  assign branch_taken = in_i.ctrl.is_branch && ((rs1_fwd == rs2_fwd) ^ in_i.ctrl.branch_ne);

  assign redirect_o = valid_i && (in_i.ctrl.is_jal || in_i.ctrl.is_jalr || branch_taken);

  assign redirect_pc_o = in_i.ctrl.is_jalr ? ((rs1_fwd + in_i.imm) & ~XLEN'(1))
                                           : (in_i.pc + in_i.imm);

  assign out_o = '{pc: in_i.pc, rd: in_i.rd, result: result,
                   reg_write: in_i.ctrl.reg_write};

  assert property (@(posedge clk) redirect_o |-> (redirect_pc_o[1:0] == 2'b00))
    else $error("redirect target not word aligned: %h", redirect_pc_o);

endmodule

/* logic/rv_core.sv */
`timescale 1ns/1ps

module rv_core
  import rv_pkg::*;
#(
  parameter logic [XLEN-1:0] RESET_PC = '0
) (
  input  logic            clk,
  input  logic            rst_n_i,
  output logic [XLEN-1:0] imem_addr_o,
  input  logic [31:0]     imem_data_i,
  output logic            wb_valid_o,
  output logic [XLEN-1:0] wb_pc_o,
  output logic [4:0]      wb_rd_o,
  output logic [XLEN-1:0] wb_data_o
);

  logic [XLEN-1:0] pc;
  logic            redirect;
  logic [XLEN-1:0] redirect_pc;
  if_id_t          if_id_d;
  if_id_t          if_id_q;
  logic            if_id_valid;
  id_ex_t          id_ex_d;
  id_ex_t          id_ex_q;
  logic            id_ex_valid;
  ex_wb_t          ex_wb_d;
  ex_wb_t          ex_wb_q;
  logic            ex_wb_valid;

  wb_if wb_bus ();

  fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (
    .clk(clk), .rst_n_i(rst_n_i), .redirect_i(redirect),
    .redirect_pc_i(redirect_pc), .pc_o(pc)
  );

  assign imem_addr_o = pc;
  assign if_id_d     = '{pc: pc, instr: imem_data_i};

  // fetch is valid as soon as reset is released
  pipe_stage_reg #(.payload_t(if_id_t)) u_if_id (
    .clk(clk), .rst_n_i(rst_n_i), .flush_i(redirect), .valid_i(rst_n_i),
    .data_i(if_id_d), .valid_o(if_id_valid), .data_o(if_id_q)
  );

  decode_unit u_decode (.in_i(if_id_q), .wb(wb_bus), .clk(clk), .out_o(id_ex_d));

  pipe_stage_reg #(.payload_t(id_ex_t)) u_id_ex (
    .clk(clk), .rst_n_i(rst_n_i), .flush_i(redirect), .valid_i(if_id_valid),
    .data_i(id_ex_d), .valid_o(id_ex_valid), .data_o(id_ex_q)
  );

  execute_unit u_execute (
    .clk(clk), .in_i(id_ex_q), .valid_i(id_ex_valid), .wb(wb_bus),
    .out_o(ex_wb_d), .redirect_o(redirect), .redirect_pc_o(redirect_pc)
  );

  // the redirecting instruction itself always retires
  pipe_stage_reg #(.payload_t(ex_wb_t)) u_ex_wb (
    .clk(clk), .rst_n_i(rst_n_i), .flush_i(1'b0), .valid_i(id_ex_valid),
    .data_i(ex_wb_d), .valid_o(ex_wb_valid), .data_o(ex_wb_q)
  );

  // rd forced to zero when nothing is written
  assign wb_bus.valid = ex_wb_valid;
  assign wb_bus.rd    = ex_wb_q.reg_write ? ex_wb_q.rd : 5'd0;
  assign wb_bus.data  = ex_wb_q.result;
  assign wb_bus.pc    = ex_wb_q.pc;

  assign wb_valid_o = wb_bus.valid;
  assign wb_pc_o    = wb_bus.pc;
  assign wb_rd_o    = wb_bus.rd;
  assign wb_data_o  = wb_bus.data;

endmodule

/* test/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD_NS    = 10,
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic rst_n_o
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // reset covers RESET_CYCLES rising edges, released on a falling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n_o = 1'b1;
  end

endmodule

/* test/rv_iss_model.svh */
`ifndef RV_ISS_MODEL_SVH
`define RV_ISS_MODEL_SVH

localparam logic [6:0]  OPC_OP     = 7'b0110011;
localparam logic [6:0]  OPC_IMM    = 7'b0010011;
localparam logic [6:0]  OPC_LUI    = 7'b0110111;
localparam logic [6:0]  OPC_AUIPC  = 7'b0010111;
localparam logic [6:0]  OPC_JAL    = 7'b1101111;
localparam logic [6:0]  OPC_JALR   = 7'b1100111;
localparam logic [6:0]  OPC_BRANCH = 7'b1100011;
localparam logic [31:0] NOP        = 32'h0000_0013;
localparam logic [31:0] SELF_LOOP  = 32'h0000_006f;

function automatic int unsigned rand_below(int unsigned n);
  return $unsigned($random(seed)) % n;
endfunction

function automatic logic [31:0] enc_branch(int off, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3);
  logic [12:0] b;
  b = off[12:0];
  return {b[12], b[10:5], rs2, rs1, f3, b[4:1], b[11], OPC_BRANCH};
endfunction

function automatic logic [31:0] enc_jal(int off, logic [4:0] rd);
  logic [20:0] j;
  j = off[20:0];
  return {j[20], j[10:1], j[11], j[19:12], rd, OPC_JAL};
endfunction

// ============================================================
// random program, forward-only control flow
// ============================================================

task automatic build_program();
  int          i;
  int          span;
  int          tgt;
  int          off;
  logic [31:0] r;
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [2:0]  f3;
  logic [6:0]  f7;
  // x1..x7 get a value before anything reads them
  for (i = 0; i < 7; i++) begin
    r = $random(seed);
    prog[6'(i)] = {r[11:0], 5'd0, 3'd0, 5'(i + 1), OPC_IMM};
  end
  i = 7;
  while (i < PROG_LEN - 1) begin
    r    = $random(seed);
    rd   = 5'(rand_below(8));
    rs1  = 5'(rand_below(8));
    rs2  = 5'(rand_below(8));
    f3   = r[14:12];
    f7   = ((f3 == 3'd0 || f3 == 3'd5) && r[30]) ? 7'h20 : 7'h00;
    span = PROG_LEN - 1 - i;
    if (span > 8) begin
      span = 8;
    end
    tgt = i + 1 + int'(rand_below(span));
    case (rand_below(10))
      0, 1, 2: prog[6'(i)] = {f7, rs2, rs1, f3, rd, OPC_OP};
      3, 4, 5: begin
        // shift immediates keep only shamt plus the sra marker
        if (f3 == 3'd1 || f3 == 3'd5) begin
          r[31:25] = f7;
        end
        prog[6'(i)] = {r[31:20], rs1, f3, rd, OPC_IMM};
      end
      6: prog[6'(i)] = {r[31:12], rd, r[0] ? OPC_LUI : OPC_AUIPC};
      7: prog[6'(i)] = enc_branch(4 * (tgt - i), rs2, rs1, {2'b00, r[0]});
      8: prog[6'(i)] = enc_jal(4 * (tgt - i), rd);
      default: begin
        if (i < PROG_LEN - 2) begin
          // auipc base then jalr, odd offset checks the bit 0 clear
          rs1  = 5'(1 + rand_below(7));
          span = PROG_LEN - 2 - i;
          if (span > 8) begin
            span = 8;
          end
          tgt = i + 2 + int'(rand_below(span));
          off = 4 * (tgt - i) + int'(r[1]);
          prog[6'(i)] = {20'd0, rs1, OPC_AUIPC};
          i++;
          prog[6'(i)] = {off[11:0], rs1, 3'd0, rd, OPC_JALR};
        end else begin
          prog[6'(i)] = NOP;
        end
      end
    endcase
    i++;
  end
  prog[PROG_LEN - 1] = SELF_LOOP;
endtask

// ============================================================
// instruction-level model
// ============================================================

function automatic logic [31:0] alu_ref(logic [2:0] f3, logic alt, logic [31:0] a,
                                        logic [31:0] b);
  case (f3)
    3'd0:    return alt ? a - b : a + b;
    3'd1:    return a << b[4:0];
    3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'd3:    return (a < b) ? 32'd1 : 32'd0;
    3'd4:    return a ^ b;
    3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'd6:    return a | b;
    default: return a & b;
  endcase
endfunction

task automatic run_model();
  logic [31:0] regs [32];
  logic [31:0] pc;
  logic [31:0] word;
  logic [31:0] ins;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] imm_i;
  logic [31:0] res;
  logic [31:0] nxt;
  logic [4:0]  rd;
  string       name;
  int          step;
  bit          at_loop;
  regs    = '{default: 32'd0};
  pc      = RESET_PC;
  at_loop = 1'b0;
  for (step = 0; step < PROG_LEN && !at_loop; step++) begin
    word  = (pc - RESET_PC) >> 2;
    ins   = prog[word[5:0]];
    rd    = ins[11:7];
    a     = regs[ins[19:15]];
    b     = regs[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    nxt   = pc + 32'd4;
    res   = pc + 32'd4;
    name  = "unknown";
    case (ins[6:0])
      OPC_OP: begin
        res  = alu_ref(ins[14:12], ins[30], a, b);
        name = "alu_reg";
      end
      OPC_IMM: begin
        res  = alu_ref(ins[14:12], ins[30] && ins[14:12] == 3'd5, a, imm_i);
        name = "alu_imm";
      end
      OPC_LUI: begin
        res  = {ins[31:12], 12'd0};
        name = "lui";
      end
      OPC_AUIPC: begin
        res  = pc + {ins[31:12], 12'd0};
        name = "auipc";
      end
      OPC_JAL: begin
        nxt  = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        name = "jal";
      end
      OPC_JALR: begin
        nxt  = (a + imm_i) & ~32'd1;
        name = "jalr";
      end
      OPC_BRANCH: begin
        // branches retire with no destination and zero data
        rd   = 5'd0;
        res  = 32'd0;
        name = "branch";
        if ((a == b) != ins[12]) begin
          nxt = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        end
      end
      default: ;
    endcase
    if (rd != 5'd0) begin
      regs[rd] = res;
    end else if (ins[6:0] != OPC_BRANCH) begin
      name = {name, "_x0"};
    end
    exp_pc.push_back(pc);
    exp_rd.push_back(rd);
    exp_data.push_back(res);
    exp_name.push_back(name);
    at_loop = (ins == SELF_LOOP);
    pc      = nxt;
  end
endtask

`endif

/* test/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;

  localparam logic [31:0] RESET_PC     = 32'h0000_1000;
  localparam int          PROG_LEN     = 64;
  localparam int          CYCLE_NS     = 10;
  localparam int          RESET_CYCLES = 2;
  localparam int          WATCHDOG_NS  = (RESET_CYCLES + 20 * PROG_LEN) * CYCLE_NS;

  logic        clk;
  logic        rst_n;
  logic [31:0] imem_addr;
  logic [31:0] imem_data;
  logic [31:0] word_off;
  logic        wb_valid;
  logic [31:0] wb_pc;
  logic [4:0]  wb_rd;
  logic [31:0] wb_data;

  integer      seed;
  logic [31:0] prog [PROG_LEN];
  logic [31:0] exp_pc [$];
  logic [4:0]  exp_rd [$];
  logic [31:0] exp_data [$];
  string       exp_name [$];
  int          model_len;
  int          retired;
  int          err_pc;
  int          err_rd;
  int          err_data;
  int          err_other;
  logic        rst_at_edge;
  bit          finished;

  `include "rv_iss_model.svh"

  tb_clock #(.PERIOD_NS(CYCLE_NS), .RESET_CYCLES(RESET_CYCLES)) u_clock (
    .clk     (clk),
    .rst_n_o (rst_n)
  );

  rv_core #(.RESET_PC(RESET_PC)) dut0 (
    .clk         (clk),
    .rst_n_i     (rst_n),
    .imem_addr_o (imem_addr),
    .imem_data_i (imem_data),
    .wb_valid_o  (wb_valid),
    .wb_pc_o     (wb_pc),
    .wb_rd_o     (wb_rd),
    .wb_data_o   (wb_data)
  );

  // same-cycle instruction memory, nop outside the program
  assign word_off  = (imem_addr - RESET_PC) >> 2;
  assign imem_data = (word_off < 32'(PROG_LEN)) ? prog[word_off[5:0]] : NOP;

  task automatic report_mismatch(string tname, string field, logic [31:0] exp_v,
                                 logic [31:0] act_v);
    $display("ERR %s %s: expected %h actual %h", tname, field, exp_v, act_v);
  endtask

  task automatic print_summary();
    $display("errors: pc %0d rd %0d data %0d other %0d, retired %0d of %0d",
             err_pc, err_rd, err_data, err_other, retired, model_len);
  endtask

  // ============================================================
  // retirement checks
  // ============================================================

  task automatic check_retirement();
    string tname;
    if (!rst_at_edge) begin
      err_other++;
      $display("retirement at pc %h while reset is held", wb_pc);
    end else begin
      tname = (retired == 0) ? "reset_first_pc" : exp_name[0];
      if (wb_pc !== exp_pc[0]) begin
        err_pc++;
        report_mismatch(tname, "pc", exp_pc[0], wb_pc);
      end
      if (wb_rd !== exp_rd[0]) begin
        err_rd++;
        report_mismatch(tname, "rd", 32'(exp_rd[0]), 32'(wb_rd));
      end
      if (wb_data !== exp_data[0]) begin
        err_data++;
        report_mismatch(tname, "data", exp_data[0], wb_data);
      end
      void'(exp_pc.pop_front());
      void'(exp_rd.pop_front());
      void'(exp_data.pop_front());
      void'(exp_name.pop_front());
      retired++;
      if (exp_pc.size() == 0) begin
        finished = 1'b1;
      end
    end
  endtask

  // reset level as the DUT saw it at the last rising edge
  always @(posedge clk) begin
    rst_at_edge <= rst_n;
  end

  // outputs sampled mid-cycle, away from the register updates
  always @(negedge clk) begin
    if (!rst_at_edge && imem_addr !== RESET_PC) begin
      err_pc++;
      report_mismatch("reset_fetch_addr", "addr", RESET_PC, imem_addr);
    end
    if (wb_valid === 1'b1 && !finished) begin
      check_retirement();
    end
  end

  initial begin
    seed        = 32'he4cf_0560;
    retired     = 0;
    err_pc      = 0;
    err_rd      = 0;
    err_data    = 0;
    err_other   = 0;
    finished    = 1'b0;
    rst_at_edge = 1'b0;
    build_program();
    run_model();
    model_len = exp_pc.size();
    wait (finished);
    print_summary();
    if (err_pc + err_rd + err_data + err_other == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the self-loop retired");
    print_summary();
    $display("TEST FAIL");
    $finish;
  end

endmodule

/* files.f */
+incdir+test
logic/rv_pkg.sv
logic/wb_if.sv
logic/pipe_stage_reg.sv
logic/fetch_unit.sv
logic/reg_file.sv
logic/decode_unit.sv
logic/execute_unit.sv
logic/rv_core.sv
test/tb_clock.sv
test/tb_rv_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SRCS := $(shell grep -v '^+' $(FILELIST)) test/rv_iss_model.svh
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BIN) | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG) || ! grep -q "TEST PASS" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
